//--- src/id_track_pkg.sv
/*
 * IDs wrap modulo MAX_IDS. ADD imm is zero-extended before the add.
 * MUL lat holds latency minus one; class code 2'b11 is treated as NOP.
 */
package id_track_pkg;

    localparam int MAX_IDS = 8;
    localparam int LOG2_MAX_IDS = 3;
    localparam int RETIRE_PORTS = 2;
    localparam int LOG2_RETIRE_PORTS = 1;

    typedef logic [LOG2_MAX_IDS-1:0] id_t;
    typedef logic [LOG2_RETIRE_PORTS:0] retire_count_t;

    typedef enum logic [1:0] {
        ADD = 2'b00,
        MUL = 2'b01,
        NOP = 2'b10
    } instr_class_t;

    ////////////////////////////////////////
    // Instruction formats with the class in bits 31:30
    typedef struct packed {
        instr_class_t cls;
        logic [4:0] rd;
        logic [8:0] unused;
        logic [15:0] imm;
    } add_fmt_t;

    typedef struct packed {
        instr_class_t cls;
        logic [4:0] rd;
        logic [1:0] lat;
        logic [7:0] imm_a;
        logic [7:0] imm_b;
        logic [6:0] spare;
    } mul_fmt_t;

    typedef union packed {
        add_fmt_t add_fmt;
        mul_fmt_t mul_fmt;
    } instr_word_t;

    ////////////////////////////////////////
    // Pipeline packets
    typedef struct packed {
        logic [31:0] pc;
        instr_word_t instruction;
    } fetch_packet_t;

    typedef struct packed {
        id_t id;
        logic valid;
        logic [31:0] pc;
        instr_word_t instruction;
    } decode_packet_t;

    typedef struct packed {
        id_t id;
        instr_class_t cls;
        logic [4:0] rd;
        logic [31:0] pc;
        logic [15:0] imm;
        logic [7:0] imm_a;
        logic [7:0] imm_b;
        logic [1:0] lat;
    } issue_packet_t;

    typedef struct packed {
        logic valid;
        id_t id;
        logic [31:0] data;
    } wb_packet_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [4:0] rd;
        logic [31:0] data;
    } result_t;

endpackage

//--- src/id_lutram.sv
/*
 * MAX_IDS deep table. Write lands at the clock edge, reads are combinational,
 * so a read of the address being written returns the old entry.
 */
`timescale 1ns/1ps

module id_lutram
    import id_track_pkg::*;
#(
    parameter int DATA_W = 32,
    parameter int NUM_READ = 1
)
(
    input logic clk,
    input logic write,
    input id_t waddr,
    input logic [DATA_W-1:0] wdata,
    input id_t raddr [NUM_READ],
    output logic [DATA_W-1:0] rdata [NUM_READ]
);

    logic [DATA_W-1:0] mem [MAX_IDS];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_READ; i++) begin
            rdata[i] = mem[raddr[i]];
        end
    end

endmodule

//--- src/id_manager.sv
/*
 * Flush drops only fetched, not yet issued instructions.
 * id_available lags the in-flight count by one registered cycle.
 */
`timescale 1ns/1ps

module id_manager
    import id_track_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic fetch_valid,
    input fetch_packet_t fetch,
    output logic id_available,
    output decode_packet_t decode,
    input logic decode_advance,
    input retire_count_t retire_count,
    output id_t oldest_id
);

    localparam int CNT_W = LOG2_MAX_IDS + 1;

    id_t fetch_id;
    id_t decode_id;
    id_t oldest_pre_issue_id;
    id_t oldest_pre_issue_next;
    id_t decode_raddr [1];
    logic [31:0] pc_rdata [1];
    logic [31:0] instr_rdata [1];
    logic fetch_xfer;
    // Held negative so the MSB flags a pending decode
    logic [CNT_W-1:0] fetched_count_neg;
    logic [CNT_W-1:0] pre_issue_count;
    logic [CNT_W-1:0] pre_issue_next;
    logic [CNT_W-1:0] post_issue_count;
    logic [CNT_W-1:0] post_issue_next;
    logic [CNT_W-1:0] inflight_count;

    ////////////////////////////////////////
    // PC and instruction tables
    assign fetch_xfer = fetch_valid & id_available;
    assign decode_raddr[0] = decode_id;

    id_lutram #(.DATA_W(32), .NUM_READ(1)) u_pc_table (
        .clk(clk),
        .write(fetch_xfer),
        .waddr(fetch_id),
        .wdata(fetch.pc),
        .raddr(decode_raddr),
        .rdata(pc_rdata)
    );

    id_lutram #(.DATA_W(32), .NUM_READ(1)) u_instr_table (
        .clk(clk),
        .write(fetch_xfer),
        .waddr(fetch_id),
        .wdata(fetch.instruction),
        .raddr(decode_raddr),
        .rdata(instr_rdata)
    );

    ////////////////////////////////////////
    // ID pointers and counters
    assign oldest_pre_issue_next = oldest_pre_issue_id + id_t'(decode_advance);
    assign pre_issue_next = pre_issue_count + CNT_W'(fetch_xfer) - CNT_W'(decode_advance);
    assign post_issue_next = post_issue_count + CNT_W'(decode_advance) - CNT_W'(retire_count);

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_id <= '0;
            decode_id <= '0;
            oldest_pre_issue_id <= '0;
            oldest_id <= '0;
            fetched_count_neg <= '0;
            pre_issue_count <= '0;
            post_issue_count <= '0;
            inflight_count <= '0;
        end else begin
            oldest_pre_issue_id <= oldest_pre_issue_next;
            oldest_id <= oldest_id + id_t'(retire_count);
            post_issue_count <= post_issue_next;
            if (flush) begin
                // Rewind to the first ID that has not issued
                fetch_id <= oldest_pre_issue_next;
                decode_id <= oldest_pre_issue_next;
                fetched_count_neg <= '0;
                pre_issue_count <= '0;
                inflight_count <= post_issue_next;
            end else begin
                fetch_id <= fetch_id + id_t'(fetch_xfer);
                decode_id <= decode_id + id_t'(decode_advance);
                fetched_count_neg <= fetched_count_neg + CNT_W'(decode_advance)
                    - CNT_W'(fetch_xfer);
                pre_issue_count <= pre_issue_next;
                inflight_count <= pre_issue_next + post_issue_next;
            end
        end
    end

    // Full pool sets the MSB of the in-flight count
    assign id_available = ~inflight_count[LOG2_MAX_IDS];

    assign decode = '{
        id: decode_id,
        valid: fetched_count_neg[CNT_W-1],
        pc: pc_rdata[0],
        instruction: instr_word_t'(instr_rdata[0])
    };

endmodule

//--- src/decoder.sv
/*
 * Issue happens in the decode cycle itself. A MUL waits for a free multiplier,
 * ADD and NOP never stall.
 */
`timescale 1ns/1ps

module decoder
    import id_track_pkg::*;
(
    input decode_packet_t decode,
    input logic mul_busy,
    output logic decode_advance,
    output logic issue_valid,
    output issue_packet_t issue
);

    instr_class_t cls;

    // Unknown class code falls back to NOP
    always_comb begin
        case (decode.instruction.add_fmt.cls)
            ADD: cls = ADD;
            MUL: cls = MUL;
            default: cls = NOP;
        endcase
    end

    assign decode_advance = decode.valid & ~((cls == MUL) & mul_busy);
    assign issue_valid = decode_advance;

    always_comb begin
        issue = '0;
        issue.id = decode.id;
        issue.pc = decode.pc;
        issue.cls = cls;
        case (cls)
            ADD: begin
                issue.rd = decode.instruction.add_fmt.rd;
                issue.imm = decode.instruction.add_fmt.imm;
            end
            MUL: begin
                issue.rd = decode.instruction.mul_fmt.rd;
                issue.imm_a = decode.instruction.mul_fmt.imm_a;
                issue.imm_b = decode.instruction.mul_fmt.imm_b;
                issue.lat = decode.instruction.mul_fmt.lat;
            end
            default: begin
                issue.rd = '0;
            end
        endcase
    end

endmodule

//--- src/exec_units.sv
/*
 * Only one MUL in flight; mul_busy stays high through its writeback cycle.
 * ADD and MUL writebacks may land in the same cycle on separate ports.
 */
`timescale 1ns/1ps

module exec_units
    import id_track_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input issue_packet_t issue,
    output logic mul_busy,
    output wb_packet_t add_wb,
    output wb_packet_t mul_wb
);

    logic mul_start;
    logic mul_done;
    logic [1:0] mul_cnt;
    id_t mul_id;
    logic [31:0] mul_product;

    ////////////////////////////////////////
    // Adder with its result one cycle after issue
    always_ff @(posedge clk) begin
        add_wb.id <= issue.id;
        add_wb.data <= issue.pc + 32'(issue.imm);
        if (rst) begin
            add_wb.valid <= 1'b0;
        end else begin
            add_wb.valid <= issue_valid & (issue.cls == ADD);
        end
    end

    ////////////////////////////////////////
    // Multiplier
    assign mul_start = issue_valid & (issue.cls == MUL);
    // Counter hits zero lat+1 cycles after issue
    assign mul_done = mul_busy & (mul_cnt == 2'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_busy <= 1'b0;
            mul_cnt <= '0;
        end else if (mul_start) begin
            mul_busy <= 1'b1;
            mul_cnt <= issue.lat;
        end else if (mul_done) begin
            mul_busy <= 1'b0;
        end else if (mul_busy) begin
            mul_cnt <= mul_cnt - 2'd1;
        end
    end

    // Product computed at issue and held until writeback
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_id <= issue.id;
            mul_product <= 32'(issue.imm_a) * 32'(issue.imm_b);
        end
    end

    assign mul_wb = '{valid: mul_done, id: mul_id, data: mul_product};

endmodule

//--- src/retirer.sv
/*
 * Retires a contiguous block from oldest_id, at most one register writer per cycle.
 * ADD and MUL always write rd, even rd 0; NOP never does.
 */
`timescale 1ns/1ps

module retirer
    import id_track_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input issue_packet_t issue,
    input wb_packet_t add_wb,
    input wb_packet_t mul_wb,
    input id_t oldest_id,
    output retire_count_t retire_count,
    output result_t result
);

    typedef struct packed {
        instr_class_t cls;
        logic [4:0] rd;
        logic [31:0] pc;
    } retire_meta_t;

    localparam int META_W = $bits(retire_meta_t);

    logic [MAX_IDS-1:0] issued;
    logic [MAX_IDS-1:0] waiting;
    logic [31:0] data_table [MAX_IDS];
    id_t retire_ids [RETIRE_PORTS];
    logic [META_W-1:0] meta_raw [RETIRE_PORTS];
    retire_meta_t meta [RETIRE_PORTS];
    logic [RETIRE_PORTS-1:0] port_valid;
    logic contiguous;
    logic writer_found;
    logic [LOG2_RETIRE_PORTS-1:0] writer_sel;

    id_lutram #(.DATA_W(META_W), .NUM_READ(RETIRE_PORTS)) u_meta_table (
        .clk(clk),
        .write(issue_valid),
        .waddr(issue.id),
        .wdata(retire_meta_t'{cls: issue.cls, rd: issue.rd, pc: issue.pc}),
        .raddr(retire_ids),
        .rdata(meta_raw)
    );

    // One data table write port per execute unit
    always_ff @(posedge clk) begin
        if (add_wb.valid) begin
            data_table[add_wb.id] <= add_wb.data;
        end
        if (mul_wb.valid) begin
            data_table[mul_wb.id] <= mul_wb.data;
        end
    end

    ////////////////////////////////////////
    // Per-ID issued and waiting bits
    always_ff @(posedge clk) begin
        if (rst) begin
            issued <= '0;
            waiting <= '0;
        end else begin
            for (int i = 0; i < RETIRE_PORTS; i++) begin
                if (port_valid[i]) begin
                    issued[retire_ids[i]] <= 1'b0;
                end
            end
            if (add_wb.valid) begin
                waiting[add_wb.id] <= 1'b0;
            end
            if (mul_wb.valid) begin
                waiting[mul_wb.id] <= 1'b0;
            end
            if (issue_valid) begin
                issued[issue.id] <= 1'b1;
                waiting[issue.id] <= (issue.cls != NOP);
            end
        end
    end

    ////////////////////////////////////////
    // Retire selection
    always_comb begin
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            retire_ids[i] = oldest_id + id_t'(i);
        end
    end

    always_comb begin
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            meta[i] = retire_meta_t'(meta_raw[i]);
        end
    end

    always_comb begin
        contiguous = 1'b1;
        writer_found = 1'b0;
        writer_sel = '0;
        retire_count = '0;
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            // Second writer in the same cycle waits
            port_valid[i] = contiguous & issued[retire_ids[i]] & ~waiting[retire_ids[i]]
                & ~((meta[i].cls != NOP) & writer_found);
            if (port_valid[i] && meta[i].cls != NOP) begin
                writer_sel = LOG2_RETIRE_PORTS'(i);
            end
            writer_found = writer_found | (port_valid[i] & (meta[i].cls != NOP));
            contiguous = contiguous & port_valid[i];
            retire_count = retire_count + retire_count_t'(port_valid[i]);
        end
    end

    always_ff @(posedge clk) begin
        result.pc <= meta[writer_sel].pc;
        result.rd <= meta[writer_sel].rd;
        result.data <= data_table[retire_ids[writer_sel]];
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= writer_found;
        end
    end

endmodule

//--- src/mini_core.sv
/*
 * In-order instruction tracker with MAX_IDS IDs in flight.
 * fetch_ready is the ID pool status; the result port has no back-pressure.
 */
`timescale 1ns/1ps

module mini_core
    import id_track_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic fetch_valid,
    input fetch_packet_t fetch,
    output logic fetch_ready,
    output result_t result
);

    decode_packet_t decode;
    logic decode_advance;
    logic issue_valid;
    issue_packet_t issue;
    logic mul_busy;
    wb_packet_t add_wb;
    wb_packet_t mul_wb;
    retire_count_t retire_count;
    id_t oldest_id;

    id_manager u_id_manager (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .fetch_valid(fetch_valid),
        .fetch(fetch),
        .id_available(fetch_ready),
        .decode(decode),
        .decode_advance(decode_advance),
        .retire_count(retire_count),
        .oldest_id(oldest_id)
    );

    decoder u_decoder (
        .decode(decode),
        .mul_busy(mul_busy),
        .decode_advance(decode_advance),
        .issue_valid(issue_valid),
        .issue(issue)
    );

    exec_units u_exec_units (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue(issue),
        .mul_busy(mul_busy),
        .add_wb(add_wb),
        .mul_wb(mul_wb)
    );

    retirer u_retirer (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue(issue),
        .add_wb(add_wb),
        .mul_wb(mul_wb),
        .oldest_id(oldest_id),
        .retire_count(retire_count),
        .result(result)
    );

endmodule

//--- verification/mini_core_tb.sv
/*
 * Random fetch stream of ADD, MUL and NOP with unique pcs, one MUL burst, one flush.
 * Instructions fetched before the flush may be skipped; later ones must all retire.
 */
`timescale 1ns/1ps

module mini_core_tb
    import id_track_pkg::*;
();

    localparam int STALL_LIMIT = 500;
    localparam int DRAIN_LIMIT = 2000;

    typedef struct packed {
        logic [31:0] pc;
        int seq;
    } expect_entry_t;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    logic fetch_valid;
    fetch_packet_t fetch;
    logic fetch_ready;
    result_t result;

    int seed;
    int fetch_seq = 0;
    int flush_seq = 0;
    int checks = 0;
    int errors = 0;
    int stim_errors = 0;
    int ready_low_cycles = 0;
    int burst_low_start;
    int flush_delay;
    instr_word_t instr_by_pc [logic [31:0]];
    // ADD and MUL still owed a result in fetch order
    expect_entry_t expect_q [$];

    always #10 clk = ~clk;

    mini_core u_mini_core (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .fetch_valid(fetch_valid),
        .fetch(fetch),
        .fetch_ready(fetch_ready),
        .result(result)
    );

    // ADD adds the zero-extended imm to pc and MUL multiplies two bytes
    function automatic logic [31:0] expected_data(input instr_word_t word, input logic [31:0] pc);
        logic [31:0] value;
        case (word.add_fmt.cls)
            ADD: value = pc + {16'h0000, word.add_fmt.imm};
            MUL: value = {24'h000000, word.mul_fmt.imm_a} * {24'h000000, word.mul_fmt.imm_b};
            default: value = '0;
        endcase
        return value;
    endfunction

    task automatic make_packet(input bit mul_only, output fetch_packet_t pkt);
        instr_word_t word;
        int pick;
        word = instr_word_t'($random(seed));
        pick = $random(seed) & 7;
        if (mul_only || (pick >= 4 && pick <= 6)) begin
            word.mul_fmt.cls = MUL;
        end else if (pick == 7) begin
            word.add_fmt.cls = NOP;
        end else begin
            word.add_fmt.cls = ADD;
        end
        pkt.instruction = word;
        pkt.pc = $random(seed);
        while (instr_by_pc.exists(pkt.pc)) begin
            pkt.pc = $random(seed);
        end
    endtask

    // Valid/ready source that holds each packet until it is taken
    task automatic send_stream(input int count, input bit mul_only, input bit hold_valid);
        int sent;
        int stall;
        bit pending;
        fetch_packet_t pkt;
        sent = 0;
        stall = 0;
        pending = 1'b0;
        while (sent < count) begin
            @(posedge clk);
            if (!pending) begin
                if (hold_valid || ($random(seed) & 3) != 0) begin
                    make_packet(mul_only, pkt);
                    fetch <= pkt;
                    fetch_valid <= 1'b1;
                    pending = 1'b1;
                end else begin
                    fetch_valid <= 1'b0;
                end
            end
            @(negedge clk);
            if (fetch_valid && fetch_ready) begin
                pending = 1'b0;
                sent++;
                stall = 0;
            end else begin
                stall++;
                if (stall > STALL_LIMIT) begin
                    $display("Timeout: fetch was not accepted for %0d cycles", STALL_LIMIT);
                    stim_errors++;
                    break;
                end
            end
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    // Wait for every instruction fetched after the last flush to retire
    task automatic drain(input string phase);
        int cycles;
        int owed;
        cycles = 0;
        owed = 1;
        while (owed > 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            owed = 0;
            foreach (expect_q[i]) begin
                if (expect_q[i].seq >= flush_seq) begin
                    owed++;
                end
            end
            cycles++;
        end
        if (owed > 0) begin
            $display("Timeout: %0d instructions of the %s phase never retired", owed, phase);
            stim_errors++;
        end
    endtask

    ////////////////////////////////////////
    // Result checker
    task automatic check_result();
        int match;
        instr_word_t word;
        logic [31:0] exp_pc;
        match = -1;
        for (int i = 0; i < expect_q.size(); i++) begin
            if (match < 0 && expect_q[i].pc == result.pc) begin
                match = i;
            end
        end
        checks++;
        assert (match >= 0) else begin
            $display("Error: result.pc %h was never fetched or already retired", result.pc);
            errors++;
        end
        if (match >= 0) begin
            exp_pc = expect_q[match].pc;
            // Only instructions dropped by a flush may be skipped
            while (match > 0) begin
                assert (expect_q[0].seq < flush_seq) else begin
                    $display("Instruction at pc %h was lost without a flush", expect_q[0].pc);
                    errors++;
                end
                void'(expect_q.pop_front());
                match--;
            end
            word = instr_by_pc[exp_pc];
            assert (result.data == expected_data(word, exp_pc)) else begin
                $display("Error: result.data %h, expected %h at pc %h",
                    result.data, expected_data(word, exp_pc), exp_pc);
                errors++;
            end
            assert (result.rd == word.add_fmt.rd) else begin
                $display("Error: result.rd %h, expected %h at pc %h",
                    result.rd, word.add_fmt.rd, exp_pc);
                errors++;
            end
            void'(expect_q.pop_front());
        end
    endtask

    task automatic record_fetch();
        expect_entry_t entry;
        instr_by_pc[fetch.pc] = fetch.instruction;
        if (fetch.instruction.add_fmt.cls == ADD || fetch.instruction.add_fmt.cls == MUL) begin
            entry.pc = fetch.pc;
            entry.seq = fetch_seq;
            expect_q.push_back(entry);
        end
        fetch_seq++;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (result.valid) begin
                check_result();
            end
            assert (fetch_ready || expect_q.size() > 0) else begin
                $display("fetch_ready is low with no instruction outstanding");
                errors++;
            end
            if (!fetch_ready) begin
                ready_low_cycles++;
            end
            if (fetch_valid && fetch_ready) begin
                record_fetch();
            end
            // A fetch taken in the flush cycle is dropped as well
            if (flush) begin
                flush_seq = fetch_seq;
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    initial begin
        seed = 89196;
        rst = 1'b1;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        send_stream(60, 1'b0, 1'b0);
        drain("mixed");

        if (stim_errors == 0) begin
            burst_low_start = ready_low_cycles;
            send_stream(24, 1'b1, 1'b1);
            drain("MUL burst");
            assert (ready_low_cycles > burst_low_start) else begin
                $display("fetch_ready never fell during the MUL burst");
                stim_errors++;
            end
        end

        if (stim_errors == 0) begin
            flush_delay = 5 + ($random(seed) & 15);
            fork
                send_stream(30, 1'b0, 1'b0);
                begin
                    repeat (flush_delay) @(posedge clk);
                    flush <= 1'b1;
                    @(posedge clk);
                    flush <= 1'b0;
                end
            join
            send_stream(30, 1'b0, 1'b0);
            drain("flush");
        end

        $display("Result checks %0d, errors %0d, stimulus errors %0d",
            checks, errors, stim_errors);
        if (errors == 0 && stim_errors == 0 && checks > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- mini_core.f
src/id_track_pkg.sv
src/id_lutram.sv
src/id_manager.sv
src/decoder.sv
src/exec_units.sv
src/retirer.sv
src/mini_core.sv
verification/mini_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mini_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mini_core_tb -f mini_core.f
output=$(./obj_dir/Vmini_core_tb)
echo "$output"
if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
